// ==== Bender.yml ====
package:
  name: jtag_top

sources:
  - include_dirs:
      - include
    files:
      - logic/jtag_pkg.sv
      - logic/jtag_ctrl_if.sv
      - logic/jtag_tap_fsm.sv
      - logic/jtag_ir.sv
      - logic/jtag_dr_bank.sv
      - logic/jtag_tdo_mux.sv
      - logic/jtag_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/jtag_top_props.sv
      - tb/jtag_top_checker.sv
      - tb/jtag_top_tb.sv

// ==== include/jtag_macros.svh ====
// ---------------------------------------
// TAP widths, IDCODE value, opcodes
// ---------------------------------------
`ifndef JTAG_MACROS_SVH
`define JTAG_MACROS_SVH

`define JTAG_IR_W          8
// Bit 0 must stay 1 per IEEE 1149.1
`define JTAG_IDCODE_VAL    32'h4a7c_1001
`define JTAG_SCAN_CTRL_W   12
`define JTAG_INT_DSR_W     4
`define JTAG_SCAN_FREQ_W   8

// Instruction codes
`define JTAG_OP_IDCODE     8'h15
`define JTAG_OP_SCAN_CTRL  8'h39
`define JTAG_OP_INT_DSR    8'h40
`define JTAG_OP_BYPASS     8'hff

`endif

// ==== jtag_top.f ====
+incdir+include
logic/jtag_pkg.sv
logic/jtag_ctrl_if.sv
logic/jtag_tap_fsm.sv
logic/jtag_ir.sv
logic/jtag_dr_bank.sv
logic/jtag_tdo_mux.sv
logic/jtag_top.sv
tb/jtag_top_props.sv
tb/jtag_top_checker.sv
tb/jtag_top_tb.sv

// ==== logic/jtag_ctrl_if.sv ====
// ---------------------------------------
// TAP strobes from controller to stages
// ---------------------------------------
`timescale 1ns/1ps

interface jtag_ctrl_if;

  logic                   capture_dr;
  logic                   shift_dr;
  logic                   update_dr;
  logic                   capture_ir;
  logic                   shift_ir;
  logic                   update_ir;
  jtag_pkg::tap_state_e   state;

  modport ctrl (
    output capture_dr, shift_dr, update_dr,
    output capture_ir, shift_ir, update_ir,
    output state
  );

  // IR stage also watches for Test-Logic-Reset
  modport ir  (input capture_ir, shift_ir, update_ir, state);
  modport dr  (input capture_dr, shift_dr, update_dr);
  modport out (input shift_ir);

endinterface

// ==== logic/jtag_dr_bank.sv ====
// ---------------------------------------
// IDCODE, BYPASS, SCAN_CTRL, INT_DSR
// and the chip test-control outputs
// ---------------------------------------
`timescale 1ns/1ps
`include "jtag_macros.svh"

module jtag_dr_bank (
  input  logic                          i_tck,
  input  logic                          i_trst_n,
  input  logic                          i_tdi,
  input  jtag_pkg::jtag_instr_e         i_instr,
  jtag_ctrl_if.dr                       ctrl,
  input  logic                          i_freeze_n,
  input  logic                          i_highz_n,
  input  logic                          i_iddq_mode,
  output logic                          o_dr_tdo,
  output logic [`JTAG_SCAN_FREQ_W-1:0]  o_scan_freq_en,
  output logic                          o_scan_cgc_ctrl,
  output logic                          o_scan_rst_ctrl,
  output logic                          o_scan_set_ctrl,
  output logic                          o_freeze_n,
  output logic                          o_highz_n,
  output logic                          o_iddq_mode
);

  logic                         sel_idcode;
  logic                         sel_bypass;
  logic                         sel_scan;
  logic                         sel_dsr;
  logic [31:0]                  idcode_sr_q;
  logic                         bypass_sr_q;
  logic [`JTAG_SCAN_CTRL_W-1:0] scan_sr_q;
  logic [`JTAG_SCAN_CTRL_W-1:0] scan_upd_q;
  logic [`JTAG_INT_DSR_W-1:0]   dsr_sr_q;
  logic [`JTAG_INT_DSR_W-1:0]   dsr_upd_q;
  logic                         test_mode;

  assign sel_idcode = (i_instr == jtag_pkg::INSTR_IDCODE);
  assign sel_bypass = (i_instr == jtag_pkg::INSTR_BYPASS);
  assign sel_scan   = (i_instr == jtag_pkg::INSTR_SCAN_CTRL);
  assign sel_dsr    = (i_instr == jtag_pkg::INSTR_INT_DSR);

  // ---------------------------------------
  // Shift stages, gated by the instruction
  // ---------------------------------------
  always_ff @(posedge i_tck or negedge i_trst_n) begin
    if (!i_trst_n) begin
      idcode_sr_q <= `JTAG_IDCODE_VAL;
      bypass_sr_q <= 1'b0;
      scan_sr_q   <= '0;
      dsr_sr_q    <= '0;
    end else begin
      if (sel_idcode && ctrl.capture_dr) begin
        idcode_sr_q <= `JTAG_IDCODE_VAL;
      end else if (sel_idcode && ctrl.shift_dr) begin
        idcode_sr_q <= {i_tdi, idcode_sr_q[31:1]};
      end
      // Bypass captures 0, then acts as a one-bit delay
      if (sel_bypass && ctrl.capture_dr) begin
        bypass_sr_q <= 1'b0;
      end else if (sel_bypass && ctrl.shift_dr) begin
        bypass_sr_q <= i_tdi;
      end
      if (sel_scan && ctrl.capture_dr) begin
        scan_sr_q <= '0;
      end else if (sel_scan && ctrl.shift_dr) begin
        scan_sr_q <= {i_tdi, scan_sr_q[`JTAG_SCAN_CTRL_W-1:1]};
      end
      if (sel_dsr && ctrl.capture_dr) begin
        dsr_sr_q <= '0;
      end else if (sel_dsr && ctrl.shift_dr) begin
        dsr_sr_q <= {i_tdi, dsr_sr_q[`JTAG_INT_DSR_W-1:1]};
      end
    end
  end

  // Update stages hold through Test-Logic-Reset
  always_ff @(posedge i_tck or negedge i_trst_n) begin
    if (!i_trst_n) begin
      scan_upd_q <= '0;
      dsr_upd_q  <= '0;
    end else begin
      if (sel_scan && ctrl.update_dr) begin
        scan_upd_q <= scan_sr_q;
      end
      if (sel_dsr && ctrl.update_dr) begin
        dsr_upd_q <= dsr_sr_q;
      end
    end
  end

  // ---------------------------------------
  // Test-control outputs
  // ---------------------------------------
  // Top SCAN_CTRL bit is spare
  assign o_scan_freq_en  = scan_upd_q[`JTAG_SCAN_FREQ_W-1:0];
  assign o_scan_cgc_ctrl = scan_upd_q[`JTAG_SCAN_FREQ_W];
  assign o_scan_rst_ctrl = scan_upd_q[`JTAG_SCAN_FREQ_W+1];
  assign o_scan_set_ctrl = scan_upd_q[`JTAG_SCAN_FREQ_W+2];

  // INT_DSR bit 0 takes over freeze, high-Z and IDDQ
  assign test_mode   = dsr_upd_q[0];
  assign o_freeze_n  = test_mode ? ~dsr_upd_q[1] : i_freeze_n;
  assign o_highz_n   = test_mode ? ~dsr_upd_q[2] : i_highz_n;
  assign o_iddq_mode = test_mode ?  dsr_upd_q[3] : i_iddq_mode;

  always_comb begin
    case (i_instr)
      jtag_pkg::INSTR_IDCODE:    o_dr_tdo = idcode_sr_q[0];
      jtag_pkg::INSTR_SCAN_CTRL: o_dr_tdo = scan_sr_q[0];
      jtag_pkg::INSTR_INT_DSR:   o_dr_tdo = dsr_sr_q[0];
      default:                   o_dr_tdo = bypass_sr_q;
    endcase
  end

endmodule

// ==== logic/jtag_ir.sv ====
// ---------------------------------------
// Instruction register and decode
// ---------------------------------------
`timescale 1ns/1ps
`include "jtag_macros.svh"

module jtag_ir (
  input  logic                  i_tck,
  input  logic                  i_trst_n,
  input  logic                  i_tdi,
  jtag_ctrl_if.ir               ctrl,
  output jtag_pkg::jtag_instr_e o_instr,
  output logic                  o_ir_tdo
);

  logic [`JTAG_IR_W-1:0] ir_shift_q;
  logic [`JTAG_IR_W-1:0] ir_upd_q;

  // Capture-IR loads zeros, Shift-IR moves toward bit 0
  always_ff @(posedge i_tck or negedge i_trst_n) begin
    if (!i_trst_n) begin
      ir_shift_q <= '0;
    end else if (ctrl.capture_ir) begin
      ir_shift_q <= '0;
    end else if (ctrl.shift_ir) begin
      ir_shift_q <= {i_tdi, ir_shift_q[`JTAG_IR_W-1:1]};
    end
  end

  // Test-Logic-Reset also brings back IDCODE
  always_ff @(posedge i_tck or negedge i_trst_n) begin
    if (!i_trst_n) begin
      ir_upd_q <= `JTAG_OP_IDCODE;
    end else if (ctrl.state == jtag_pkg::TAP_TEST_LOGIC_RESET) begin
      ir_upd_q <= `JTAG_OP_IDCODE;
    end else if (ctrl.update_ir) begin
      ir_upd_q <= ir_shift_q;
    end
  end

  always_comb begin
    case (ir_upd_q)
      `JTAG_OP_IDCODE:    o_instr = jtag_pkg::INSTR_IDCODE;
      `JTAG_OP_SCAN_CTRL: o_instr = jtag_pkg::INSTR_SCAN_CTRL;
      `JTAG_OP_INT_DSR:   o_instr = jtag_pkg::INSTR_INT_DSR;
      `JTAG_OP_BYPASS:    o_instr = jtag_pkg::INSTR_BYPASS;
      // Unknown codes fall back to bypass
      default:            o_instr = jtag_pkg::INSTR_BYPASS;
    endcase
  end

  assign o_ir_tdo = ir_shift_q[0];

endmodule

// ==== logic/jtag_pkg.sv ====
// ---------------------------------------
// TAP state and decoded instruction types
// ---------------------------------------
package jtag_pkg;

  // Standard TAP encoding
  typedef enum logic [3:0] {
    TAP_EXIT2_DR         = 4'h0,
    TAP_EXIT1_DR         = 4'h1,
    TAP_SHIFT_DR         = 4'h2,
    TAP_PAUSE_DR         = 4'h3,
    TAP_SELECT_IR_SCAN   = 4'h4,
    TAP_UPDATE_DR        = 4'h5,
    TAP_CAPTURE_DR       = 4'h6,
    TAP_SELECT_DR_SCAN   = 4'h7,
    TAP_EXIT2_IR         = 4'h8,
    TAP_EXIT1_IR         = 4'h9,
    TAP_SHIFT_IR         = 4'hA,
    TAP_PAUSE_IR         = 4'hB,
    TAP_RUN_TEST_IDLE    = 4'hC,
    TAP_UPDATE_IR        = 4'hD,
    TAP_CAPTURE_IR       = 4'hE,
    TAP_TEST_LOGIC_RESET = 4'hF
  } tap_state_e;

  typedef enum logic [1:0] {
    INSTR_BYPASS    = 2'd0,
    INSTR_IDCODE    = 2'd1,
    INSTR_SCAN_CTRL = 2'd2,
    INSTR_INT_DSR   = 2'd3
  } jtag_instr_e;

endpackage

// ==== logic/jtag_tap_fsm.sv ====
// ---------------------------------------
// TAP controller FSM and strobe decode
// ---------------------------------------
`timescale 1ns/1ps

module jtag_tap_fsm (
  input  logic        i_tck,
  input  logic        i_trst_n,
  input  logic        i_tms,
  jtag_ctrl_if.ctrl   ctrl
);

  jtag_pkg::tap_state_e state_q;
  jtag_pkg::tap_state_e state_d;

  always_ff @(posedge i_tck or negedge i_trst_n) begin
    if (!i_trst_n) begin
      state_q <= jtag_pkg::TAP_TEST_LOGIC_RESET;
    end else begin
      state_q <= state_d;
    end
  end

  // ---------------------------------------
  // IEEE 1149.1 next-state table
  // ---------------------------------------
  always_comb begin
    case (state_q)
      jtag_pkg::TAP_TEST_LOGIC_RESET:
        state_d = i_tms ? jtag_pkg::TAP_TEST_LOGIC_RESET : jtag_pkg::TAP_RUN_TEST_IDLE;
      jtag_pkg::TAP_RUN_TEST_IDLE:
        state_d = i_tms ? jtag_pkg::TAP_SELECT_DR_SCAN : jtag_pkg::TAP_RUN_TEST_IDLE;
      jtag_pkg::TAP_SELECT_DR_SCAN:
        state_d = i_tms ? jtag_pkg::TAP_SELECT_IR_SCAN : jtag_pkg::TAP_CAPTURE_DR;
      jtag_pkg::TAP_CAPTURE_DR:
        state_d = i_tms ? jtag_pkg::TAP_EXIT1_DR : jtag_pkg::TAP_SHIFT_DR;
      jtag_pkg::TAP_SHIFT_DR:
        state_d = i_tms ? jtag_pkg::TAP_EXIT1_DR : jtag_pkg::TAP_SHIFT_DR;
      jtag_pkg::TAP_EXIT1_DR:
        state_d = i_tms ? jtag_pkg::TAP_UPDATE_DR : jtag_pkg::TAP_PAUSE_DR;
      jtag_pkg::TAP_PAUSE_DR:
        state_d = i_tms ? jtag_pkg::TAP_EXIT2_DR : jtag_pkg::TAP_PAUSE_DR;
      jtag_pkg::TAP_EXIT2_DR:
        state_d = i_tms ? jtag_pkg::TAP_UPDATE_DR : jtag_pkg::TAP_SHIFT_DR;
      jtag_pkg::TAP_UPDATE_DR:
        state_d = i_tms ? jtag_pkg::TAP_SELECT_DR_SCAN : jtag_pkg::TAP_RUN_TEST_IDLE;
      jtag_pkg::TAP_SELECT_IR_SCAN:
        state_d = i_tms ? jtag_pkg::TAP_TEST_LOGIC_RESET : jtag_pkg::TAP_CAPTURE_IR;
      jtag_pkg::TAP_CAPTURE_IR:
        state_d = i_tms ? jtag_pkg::TAP_EXIT1_IR : jtag_pkg::TAP_SHIFT_IR;
      jtag_pkg::TAP_SHIFT_IR:
        state_d = i_tms ? jtag_pkg::TAP_EXIT1_IR : jtag_pkg::TAP_SHIFT_IR;
      jtag_pkg::TAP_EXIT1_IR:
        state_d = i_tms ? jtag_pkg::TAP_UPDATE_IR : jtag_pkg::TAP_PAUSE_IR;
      jtag_pkg::TAP_PAUSE_IR:
        state_d = i_tms ? jtag_pkg::TAP_EXIT2_IR : jtag_pkg::TAP_PAUSE_IR;
      jtag_pkg::TAP_EXIT2_IR:
        state_d = i_tms ? jtag_pkg::TAP_UPDATE_IR : jtag_pkg::TAP_SHIFT_IR;
      jtag_pkg::TAP_UPDATE_IR:
        state_d = i_tms ? jtag_pkg::TAP_SELECT_DR_SCAN : jtag_pkg::TAP_RUN_TEST_IDLE;
      default:
        state_d = jtag_pkg::TAP_TEST_LOGIC_RESET;
    endcase
  end

  // Strobes are pure state decodes, high for the whole state cycle
  assign ctrl.capture_dr = (state_q == jtag_pkg::TAP_CAPTURE_DR);
  assign ctrl.shift_dr   = (state_q == jtag_pkg::TAP_SHIFT_DR);
  assign ctrl.update_dr  = (state_q == jtag_pkg::TAP_UPDATE_DR);
  assign ctrl.capture_ir = (state_q == jtag_pkg::TAP_CAPTURE_IR);
  assign ctrl.shift_ir   = (state_q == jtag_pkg::TAP_SHIFT_IR);
  assign ctrl.update_ir  = (state_q == jtag_pkg::TAP_UPDATE_IR);
  assign ctrl.state      = state_q;

endmodule

// ==== logic/jtag_tdo_mux.sv ====
// ---------------------------------------
// Serial output select and TDO retime
// ---------------------------------------
`timescale 1ns/1ps

module jtag_tdo_mux (
  input  logic        i_tck,
  input  logic        i_trst_n,
  input  logic        i_ir_tdo,
  input  logic        i_dr_tdo,
  jtag_ctrl_if.out    ctrl,
  output logic        o_tdo
);

  logic tdo_sel;

  // IR path only while in Shift-IR
  assign tdo_sel = ctrl.shift_ir ? i_ir_tdo : i_dr_tdo;

  // Falling edge, so TDO is stable around the next rising edge
  always_ff @(negedge i_tck or negedge i_trst_n) begin
    if (!i_trst_n) begin
      o_tdo <= 1'b0;
    end else begin
      o_tdo <= tdo_sel;
    end
  end

endmodule

// ==== logic/jtag_top.sv ====
// ---------------------------------------
// TAP top level, controller to TDO
// ---------------------------------------
`timescale 1ns/1ps
`include "jtag_macros.svh"

module jtag_top (
  input  logic                          i_tck,
  input  logic                          i_trst_n,
  input  logic                          i_tms,
  input  logic                          i_tdi,
  input  logic                          i_freeze_n,
  input  logic                          i_highz_n,
  input  logic                          i_iddq_mode,
  output logic                          o_tdo,
  output logic [`JTAG_SCAN_FREQ_W-1:0]  o_scan_freq_en,
  output logic                          o_scan_cgc_ctrl,
  output logic                          o_scan_rst_ctrl,
  output logic                          o_scan_set_ctrl,
  output logic                          o_freeze_n,
  output logic                          o_highz_n,
  output logic                          o_iddq_mode
);

  jtag_pkg::jtag_instr_e instr;
  logic                  ir_tdo;
  logic                  dr_tdo;

  jtag_ctrl_if u_ctrl_if ();

  jtag_tap_fsm u_tap_fsm (
    .i_tck    (i_tck),
    .i_trst_n (i_trst_n),
    .i_tms    (i_tms),
    .ctrl     (u_ctrl_if.ctrl)
  );

  jtag_ir u_ir (
    .i_tck    (i_tck),
    .i_trst_n (i_trst_n),
    .i_tdi    (i_tdi),
    .ctrl     (u_ctrl_if.ir),
    .o_instr  (instr),
    .o_ir_tdo (ir_tdo)
  );

  jtag_dr_bank u_dr_bank (
    .i_tck           (i_tck),
    .i_trst_n        (i_trst_n),
    .i_tdi           (i_tdi),
    .i_instr         (instr),
    .ctrl            (u_ctrl_if.dr),
    .i_freeze_n      (i_freeze_n),
    .i_highz_n       (i_highz_n),
    .i_iddq_mode     (i_iddq_mode),
    .o_dr_tdo        (dr_tdo),
    .o_scan_freq_en  (o_scan_freq_en),
    .o_scan_cgc_ctrl (o_scan_cgc_ctrl),
    .o_scan_rst_ctrl (o_scan_rst_ctrl),
    .o_scan_set_ctrl (o_scan_set_ctrl),
    .o_freeze_n      (o_freeze_n),
    .o_highz_n       (o_highz_n),
    .o_iddq_mode     (o_iddq_mode)
  );

  jtag_tdo_mux u_tdo_mux (
    .i_tck    (i_tck),
    .i_trst_n (i_trst_n),
    .i_ir_tdo (ir_tdo),
    .i_dr_tdo (dr_tdo),
    .ctrl     (u_ctrl_if.out),
    .o_tdo    (o_tdo)
  );

endmodule

// ==== tb/jtag_top_checker.sv ====
// ---------------------------------------
// TAP reference model, scan and output checks
// ---------------------------------------
`timescale 1ns/1ps
`include "jtag_macros.svh"

module jtag_top_checker (
  input  logic                         i_tck,
  input  logic                         i_trst_n,
  input  logic                         i_tms,
  input  logic                         i_tdi,
  input  logic                         i_freeze_n,
  input  logic                         i_highz_n,
  input  logic                         i_iddq_mode,
  input  logic                         i_tdo,
  input  logic [`JTAG_SCAN_FREQ_W-1:0] i_scan_freq_en,
  input  logic                         i_scan_cgc_ctrl,
  input  logic                         i_scan_rst_ctrl,
  input  logic                         i_scan_set_ctrl,
  input  logic                         i_out_freeze_n,
  input  logic                         i_out_highz_n,
  input  logic                         i_out_iddq_mode,
  input  int                           i_test_num,
  input  logic                         i_test_done,
  output int                           o_err_cnt,
  output int                           o_check_cnt
);

  // Next-state tables, one nibble per state, Test-Logic-Reset in the top nibble
  localparam logic [63:0] NEXT_TMS0 = 64'hCACC_BABA_62CE_3232;
  localparam logic [63:0] NEXT_TMS1 = 64'hF977_89DD_417F_0155;

  logic [3:0]                   state_m;
  logic [`JTAG_IR_W-1:0]        ir_code_m;
  logic [`JTAG_SCAN_CTRL_W-1:0] scan_m;
  logic [`JTAG_INT_DSR_W-1:0]   dsr_m;
  logic [63:0]                  tdi_bits;
  logic [63:0]                  tdo_bits;
  logic [13:0]                  out_exp;
  logic [13:0]                  out_act;
  int                           nbits;
  int                           scan_checks = 0;
  int                           scan_errs = 0;
  int                           out_checks = 0;
  int                           out_errs = 0;
  int                           err_mark = 0;

  assign o_err_cnt   = scan_errs + out_errs;
  assign o_check_cnt = scan_checks + out_checks;

  function automatic logic [3:0] next_state(logic [3:0] cur, logic tms);
    logic [63:0] tbl;
    tbl = tms ? NEXT_TMS1 : NEXT_TMS0;
    return tbl[cur*4 +: 4];
  endfunction

  function automatic int dr_width(logic [7:0] code);
    case (code)
      `JTAG_OP_IDCODE:    return 32;
      `JTAG_OP_SCAN_CTRL: return `JTAG_SCAN_CTRL_W;
      `JTAG_OP_INT_DSR:   return `JTAG_INT_DSR_W;
      default:            return 1;
    endcase
  endfunction

  // Serial stream seen at TDO: captured bits first, then TDI
  function automatic logic [127:0] scan_stream(int width, logic [31:0] cap, logic [63:0] tdi);
    logic [127:0] mask;
    mask = (128'd1 << width) - 128'd1;
    return (128'(tdi) << width) | (128'(cap) & mask);
  endfunction

  function automatic logic [13:0] exp_outputs(logic [11:0] scan, logic [3:0] dsr,
                                              logic frz, logic hz, logic iddq);
    logic [2:0] pins;
    pins = dsr[0] ? {~dsr[1], ~dsr[2], dsr[3]} : {frz, hz, iddq};
    return {scan[7:0], scan[8], scan[9], scan[10], pins};
  endfunction

  task automatic compare_scan(input string what, input int width, input logic [31:0] cap,
                              output logic [63:0] contents);
    logic [127:0] stream;
    logic [63:0]  mask;
    stream   = scan_stream(width, cap, tdi_bits);
    mask     = (64'd1 << nbits) - 64'd1;
    contents = stream[nbits +: 64];
    scan_checks++;
    if ((tdo_bits & mask) !== (stream[63:0] & mask)) begin
      scan_errs++;
      $display("Fail o_tdo (%s scan, %0d bits): expected 0x%h, got 0x%h",
               what, nbits, stream[63:0] & mask, tdo_bits & mask);
    end
  endtask

  task automatic finish_dr_scan();
    logic [63:0] contents;
    logic [31:0] cap;
    cap = (ir_code_m == `JTAG_OP_IDCODE) ? `JTAG_IDCODE_VAL : 32'h0;
    compare_scan("DR", dr_width(ir_code_m), cap, contents);
    if (ir_code_m == `JTAG_OP_SCAN_CTRL) begin
      scan_m = contents[`JTAG_SCAN_CTRL_W-1:0];
    end
    if (ir_code_m == `JTAG_OP_INT_DSR) begin
      dsr_m = contents[`JTAG_INT_DSR_W-1:0];
    end
  endtask

  // ---------------------------------------
  // Model follows TMS on each rising edge
  // ---------------------------------------
  always @(posedge i_tck or negedge i_trst_n) begin
    logic [63:0] ir_contents;
    if (!i_trst_n) begin
      state_m   = jtag_pkg::TAP_TEST_LOGIC_RESET;
      ir_code_m = `JTAG_OP_IDCODE;
      scan_m    = '0;
      dsr_m     = '0;
      nbits     = 0;
    end else begin
      case (state_m)
        jtag_pkg::TAP_CAPTURE_DR, jtag_pkg::TAP_CAPTURE_IR: begin
          nbits = 0;
        end
        jtag_pkg::TAP_SHIFT_DR, jtag_pkg::TAP_SHIFT_IR: begin
          tdi_bits[nbits] = i_tdi;
          tdo_bits[nbits] = i_tdo;
          nbits++;
        end
        jtag_pkg::TAP_UPDATE_IR: begin
          compare_scan("IR", `JTAG_IR_W, 32'h0, ir_contents);
          ir_code_m = ir_contents[`JTAG_IR_W-1:0];
        end
        jtag_pkg::TAP_UPDATE_DR: finish_dr_scan();
        jtag_pkg::TAP_TEST_LOGIC_RESET: ir_code_m = `JTAG_OP_IDCODE;
        default: ;
      endcase
      state_m = next_state(state_m, i_tms);
    end
  end

  // Test outputs are settled by the falling edge
  always @(negedge i_tck) begin
    if (i_trst_n) begin
      out_exp = exp_outputs(scan_m, dsr_m, i_freeze_n, i_highz_n, i_iddq_mode);
      out_act = {i_scan_freq_en, i_scan_cgc_ctrl, i_scan_rst_ctrl, i_scan_set_ctrl,
                 i_out_freeze_n, i_out_highz_n, i_out_iddq_mode};
      out_checks++;
      if (out_act !== out_exp) begin
        out_errs++;
        $display("Fail test outputs {freq_en,cgc,rst,set,freeze_n,highz_n,iddq}: "
                 , "expected 0x%h, got 0x%h", out_exp, out_act);
      end
    end
  end

  always @(posedge i_tck) begin
    if (i_test_done) begin
      if (o_err_cnt == err_mark) begin
        $display("Test %0d done: PASS", i_test_num);
      end else begin
        $display("Test %0d done: FAIL, %0d mismatches", i_test_num, o_err_cnt - err_mark);
      end
      err_mark = o_err_cnt;
    end
  end

endmodule

// ==== tb/jtag_top_props.sv ====
// ---------------------------------------
// TAP strobe assertions, bound to the FSM
// ---------------------------------------
`timescale 1ns/1ps

module jtag_top_props (
  input logic       i_tck,
  input logic       i_trst_n,
  input logic       i_tms,
  input logic       i_capture_dr,
  input logic       i_shift_dr,
  input logic       i_update_dr,
  input logic       i_capture_ir,
  input logic       i_shift_ir,
  input logic       i_update_ir,
  input logic [3:0] i_state
);

  int fail_cnt = 0;

  a_strobes_onehot: assert property (@(posedge i_tck) disable iff (!i_trst_n)
    $onehot0({i_capture_dr, i_shift_dr, i_update_dr, i_capture_ir, i_shift_ir, i_update_ir}))
  else begin
    fail_cnt++;
    $error("More than one TAP strobe is high");
  end

  // Five TMS highs reach Test-Logic-Reset from any state
  a_tms_reset: assert property (@(posedge i_tck) disable iff (!i_trst_n)
    i_tms [*5] |=> (i_state == jtag_pkg::TAP_TEST_LOGIC_RESET))
  else begin
    fail_cnt++;
    $error("TAP not in Test-Logic-Reset after five cycles of TMS high");
  end

  a_capture_dr_next: assert property (@(posedge i_tck) disable iff (!i_trst_n)
    i_capture_dr |=> (i_shift_dr || i_state == jtag_pkg::TAP_EXIT1_DR))
  else begin
    fail_cnt++;
    $error("Capture-DR not followed by Shift-DR or Exit1-DR");
  end

endmodule

bind jtag_tap_fsm jtag_top_props u_props (
  .i_tck        (i_tck),
  .i_trst_n     (i_trst_n),
  .i_tms        (i_tms),
  .i_capture_dr (ctrl.capture_dr),
  .i_shift_dr   (ctrl.shift_dr),
  .i_update_dr  (ctrl.update_dr),
  .i_capture_ir (ctrl.capture_ir),
  .i_shift_ir   (ctrl.shift_ir),
  .i_update_ir  (ctrl.update_ir),
  .i_state      (ctrl.state)
);

// ==== tb/jtag_top_tb.sv ====
// ---------------------------------------
// TAP testbench: clock, reset, scans, timeout
// ---------------------------------------
`timescale 1ns/1ps
`include "jtag_macros.svh"

module jtag_top_tb;

  localparam logic [31:0] SEED = 32'h78be;
  // Sum of all IR and DR scan lengths in the sequence below
  localparam int SCAN_BITS  = 32 + 2 * (8 + 16) + (12 + 12) + (8 + 12 + 12) + (8 + 4 + 4) + 32;
  localparam int MAX_CYCLES = 2 * SCAN_BITS + 200;

  logic       i_tck;
  logic       i_trst_n;
  logic       i_tms;
  logic       i_tdi;
  logic       i_freeze_n;
  logic       i_highz_n;
  logic       i_iddq_mode;
  logic       o_tdo;
  logic [7:0] o_scan_freq_en;
  logic       o_scan_cgc_ctrl;
  logic       o_scan_rst_ctrl;
  logic       o_scan_set_ctrl;
  logic       o_freeze_n;
  logic       o_highz_n;
  logic       o_iddq_mode;
  int         test_num;
  logic       test_done;
  int         err_cnt;
  int         check_cnt;
  int         cycles = 0;

  jtag_top uut (.*);

  jtag_top_checker u_chk (
    .i_tck (i_tck), .i_trst_n (i_trst_n), .i_tms (i_tms), .i_tdi (i_tdi),
    .i_freeze_n (i_freeze_n), .i_highz_n (i_highz_n), .i_iddq_mode (i_iddq_mode),
    .i_tdo (o_tdo), .i_scan_freq_en (o_scan_freq_en), .i_scan_cgc_ctrl (o_scan_cgc_ctrl),
    .i_scan_rst_ctrl (o_scan_rst_ctrl), .i_scan_set_ctrl (o_scan_set_ctrl),
    .i_out_freeze_n (o_freeze_n), .i_out_highz_n (o_highz_n), .i_out_iddq_mode (o_iddq_mode),
    .i_test_num (test_num), .i_test_done (test_done),
    .o_err_cnt (err_cnt), .o_check_cnt (check_cnt)
  );

  always #5 i_tck = ~i_tck;

  always @(posedge i_tck) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // Drive TMS and TDI for one cycle, return 1 ns after the next rising edge
  task automatic tck_cycle(input logic tms, input logic tdi);
    i_tms = tms;
    i_tdi = tdi;
    @(posedge i_tck);
    #1;
  endtask

  task automatic shift_bits(input logic [63:0] data, input int n);
    for (int i = 0; i < n; i++) begin
      tck_cycle(i == n - 1, data[i]);
    end
    tck_cycle(1'b1, 1'b0);
    tck_cycle(1'b0, 1'b0);
  endtask

  task automatic ir_scan(input logic [63:0] data, input int n);
    tck_cycle(1'b1, 1'b0);
    tck_cycle(1'b1, 1'b0);
    tck_cycle(1'b0, 1'b0);
    tck_cycle(1'b0, 1'b0);
    shift_bits(data, n);
  endtask

  task automatic dr_scan(input logic [63:0] data, input int n);
    tck_cycle(1'b1, 1'b0);
    tck_cycle(1'b0, 1'b0);
    tck_cycle(1'b0, 1'b0);
    shift_bits(data, n);
  endtask

  task automatic drive_random_pins(input int n);
    repeat (n) begin
      {i_freeze_n, i_highz_n, i_iddq_mode} = 3'($urandom);
      tck_cycle(1'b0, 1'b0);
    end
  endtask

  task automatic end_test();
    test_done = 1'b1;
    tck_cycle(1'b0, 1'b0);
    test_done = 1'b0;
    test_num++;
  endtask

  initial begin
    logic [7:0] code;
    int         total_errs;
    void'($urandom(SEED));
    i_tck       = 1'b0;
    i_trst_n    = 1'b0;
    i_tms       = 1'b1;
    i_tdi       = 1'b0;
    i_freeze_n  = 1'b1;
    i_highz_n   = 1'b1;
    i_iddq_mode = 1'b0;
    test_num    = 1;
    test_done   = 1'b0;
    repeat (3) @(posedge i_tck);
    #1;
    i_trst_n = 1'b1;
    tck_cycle(1'b0, 1'b0);

    // IDCODE after reset
    dr_scan({$urandom, $urandom}, 32);
    end_test();
    // BYPASS code, then an unknown code
    ir_scan(`JTAG_OP_BYPASS, 8);
    dr_scan({$urandom, $urandom}, 16);
    do begin
      code = 8'($urandom);
    end while (code == `JTAG_OP_IDCODE || code == `JTAG_OP_SCAN_CTRL ||
               code == `JTAG_OP_INT_DSR || code == `JTAG_OP_BYPASS);
    ir_scan(code, 8);
    dr_scan({$urandom, $urandom}, 16);
    end_test();
    // Long IR scan, last 8 bits land in the IR
    ir_scan({`JTAG_OP_SCAN_CTRL, 4'($urandom)}, 12);
    dr_scan({$urandom, $urandom}, 12);
    end_test();
    // SCAN_CTRL write, then read back the capture
    ir_scan(`JTAG_OP_SCAN_CTRL, 8);
    dr_scan({$urandom, $urandom}, 12);
    dr_scan({$urandom, $urandom}, 12);
    end_test();
    // INT_DSR override on, then off
    ir_scan(`JTAG_OP_INT_DSR, 8);
    dr_scan(64'($urandom) | 64'h1, 4);
    drive_random_pins(8);
    dr_scan(64'($urandom) & ~64'h1, 4);
    drive_random_pins(8);
    end_test();
    // TMS reset brings back IDCODE
    repeat (5) tck_cycle(1'b1, 1'b0);
    tck_cycle(1'b0, 1'b0);
    dr_scan({$urandom, $urandom}, 32);
    end_test();

    total_errs = err_cnt + uut.u_tap_fsm.u_props.fail_cnt;
    $display("Summary: %0d tests, %0d checks, %0d errors", test_num - 1, check_cnt, total_errs);
    if (total_errs == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule
